// ==== source/cache_pkg.sv ====
package cache_pkg;

    // ------------------------------
    // Cache geometry
    // ------------------------------

    // Width of the tag kept for every line
    localparam int TAG_SIZE = 8;

    // Width of the line index, which selects one entry in every memory
    localparam int INDEX_WIDTH = 4;

    // One line per index value, since the cache is direct mapped
    localparam int CACHE_DEPTH = 1 << INDEX_WIDTH;

    // Each line carries a single data word
    localparam int WORD_WIDTH = 32;

    typedef logic [TAG_SIZE - 1:0]    tag_t;
    typedef logic [INDEX_WIDTH - 1:0] index_t;
    typedef logic [WORD_WIDTH - 1:0]  word_t;

    // ------------------------------
    // Request and response bundles
    // ------------------------------

    // Full word address, the tag sits in the upper bits
    typedef struct packed {
        tag_t   tag;
        index_t index;
    } cache_addr_t;

    // Single-cycle lookup strobe with the address to look up
    typedef struct packed {
        logic        read;
        cache_addr_t addr;
    } lookup_req_t;

    // Single-cycle fill strobe, it replaces the whole line at addr.index
    typedef struct packed {
        logic        write;
        cache_addr_t addr;
        word_t       data;
    } fill_req_t;

    // Lookup answer, data is forced to zero when the lookup misses
    typedef struct packed {
        logic  valid;
        logic  hit;
        word_t data;
    } lookup_resp_t;

    // Line pushed out by a fill, handed to the write-back path
    typedef struct packed {
        logic        valid;
        cache_addr_t addr;
        word_t       data;
    } victim_t;

endpackage : cache_pkg

// ==== source/dual_port_memory.sv ====
module dual_port_memory import cache_pkg::*; #(
    // Payload stored in every entry, tags and data words share this module
    parameter type entry_t = word_t
) (
    input  logic   clk_i,

    // Port 0 reads and writes
    input  index_t port0_index_i,
    input  entry_t port0_entry_i,
    input  logic   port0_write_i,
    input  logic   port0_read_i,
    output entry_t port0_entry_o,

    // Port 1 only reads
    input  index_t port1_index_i,
    input  logic   port1_read_i,
    output entry_t port1_entry_o
);

    // ------------------------------
    // Storage array
    // ------------------------------

    // One entry per cache line
    // The array has no reset, so the valid bits decide which entries mean anything
    entry_t memory_q [CACHE_DEPTH - 1:0];

    // Write and read on the same port at the same edge
    // The nonblocking write lands after the read, so the read sees the old entry
    // This is what lets a fill pick up the line it is about to replace
    always_ff @(posedge clk_i) begin : port0_access
        if (port0_write_i) begin
            memory_q[port0_index_i] <= port0_entry_i;
        end
        if (port0_read_i) begin
            port0_entry_o <= memory_q[port0_index_i];
        end
    end : port0_access

    // Lookups read here
    // A lookup on the same edge as a fill to the same index also gets the old entry
    // The output holds its last value while no read is requested
    always_ff @(posedge clk_i) begin : port1_access
        if (port1_read_i) begin
            port1_entry_o <= memory_q[port1_index_i];
        end
    end : port1_access

endmodule : dual_port_memory

// ==== source/valid_memory.sv ====
module valid_memory import cache_pkg::*; (
    input  logic   clk_i,
    input  logic   reset_i,

    // Fill side, marks a line valid
    input  logic   set_i,
    input  index_t set_index_i,

    // Invalidate side, drops a single line
    input  logic   clear_i,
    input  index_t clear_index_i,

    // Read port that follows the fills
    input  logic   port0_read_i,
    input  index_t port0_index_i,
    output logic   port0_valid_o,

    // Read port that follows the lookups
    input  logic   port1_read_i,
    input  index_t port1_index_i,
    output logic   port1_valid_o
);

    // ------------------------------
    // Valid bit per line
    // ------------------------------

    logic [CACHE_DEPTH - 1:0] valid_q;

    // The clear is applied first so that a set to the same index overrides it
    // A fill and an invalidate on one edge therefore leave the line valid
    always_ff @(posedge clk_i) begin : valid_bits
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            if (clear_i) begin
                valid_q[clear_index_i] <= 1'b0;
            end
            if (set_i) begin
                valid_q[set_index_i] <= 1'b1;
            end
        end
    end : valid_bits

    // ------------------------------
    // Registered reads
    // ------------------------------

    // Same one cycle delay as the tag and data memories so the three line up
    // Reads see the bits from before the edge, matching read-before-write
    always_ff @(posedge clk_i) begin : read_ports
        if (reset_i) begin
            port0_valid_o <= 1'b0;
            port1_valid_o <= 1'b0;
        end else begin
            if (port0_read_i) begin
                port0_valid_o <= valid_q[port0_index_i];
            end
            if (port1_read_i) begin
                port1_valid_o <= valid_q[port1_index_i];
            end
        end
    end : read_ports

endmodule : valid_memory

// ==== source/hit_detector.sv ====
module hit_detector import cache_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,

    // Lookup as it enters the memories
    input  lookup_req_t  lookup_i,

    // Line contents one cycle later, from the read-only ports
    input  tag_t         stored_tag_i,
    input  word_t        stored_data_i,
    input  logic         stored_valid_i,

    output lookup_resp_t response_o
);

    // ------------------------------
    // First stage, lookup in flight
    // ------------------------------

    // Strobe delayed to line up with the registered memory reads
    logic pending_q;

    // Requested tag, kept for the comparison in the next cycle
    tag_t tag_q;

    always_ff @(posedge clk_i) begin : lookup_stage
        // The tag is plain payload and only matters while pending_q is high
        tag_q <= lookup_i.addr.tag;
        if (reset_i) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= lookup_i.read;
        end
    end : lookup_stage

    // ------------------------------
    // Second stage, compare
    // ------------------------------

    // Unwritten lines may hold any tag, the valid bit masks them out
    logic hit_c;

    assign hit_c = stored_valid_i && (stored_tag_i == tag_q);

    lookup_resp_t response_q;

    always_ff @(posedge clk_i) begin : response_stage
        // Data goes to zero on a miss so a stale word never leaks out
        response_q.data <= hit_c ? stored_data_i : '0;
        if (reset_i) begin
            response_q.valid <= 1'b0;
            response_q.hit   <= 1'b0;
        end else begin
            // One pulse per lookup, and hit is only raised together with valid
            response_q.valid <= pending_q;
            response_q.hit   <= pending_q && hit_c;
        end
    end : response_stage

    assign response_o = response_q;

endmodule : hit_detector

// ==== source/eviction_builder.sv ====
module eviction_builder import cache_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,

    // Fill as it enters the memories
    input  fill_req_t fill_i,

    // Old line contents read by port 0 on the fill edge
    input  tag_t      old_tag_i,
    input  word_t     old_data_i,
    input  logic      old_valid_i,

    output victim_t   victim_o
);

    // ------------------------------
    // Fill in flight
    // ------------------------------

    // Strobe delayed by one cycle, in step with the port 0 read registers
    logic pending_q;

    // Index of the replaced line, the memories return only its tag
    index_t index_q;

    always_ff @(posedge clk_i) begin : fill_stage
        index_q <= fill_i.addr.index;
        if (reset_i) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= fill_i.write;
        end
    end : fill_stage

    // ------------------------------
    // Victim report
    // ------------------------------

    // Without dirty tracking every valid line that gets replaced is reported
    // A fill into an empty line raises nothing
    always_comb begin : victim_build
        victim_o.valid      = pending_q && old_valid_i;
        victim_o.addr.tag   = old_tag_i;
        victim_o.addr.index = index_q;
        victim_o.data       = old_data_i;
    end : victim_build

endmodule : eviction_builder

// ==== source/cache_lookup_top.sv ====
module cache_lookup_top import cache_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,

    // Single-cycle strobes, nothing here can stall
    input  lookup_req_t  lookup_i,
    input  fill_req_t    fill_i,
    input  logic         invalidate_i,
    input  index_t       invalidate_index_i,

    output lookup_resp_t response_o,
    output victim_t      victim_o
);

    // ------------------------------
    // Line storage
    // ------------------------------

    // Port 0 outputs carry the line a fill is replacing
    tag_t  old_tag;
    word_t old_data;
    logic  old_valid;

    // Port 1 outputs carry the line a lookup asked for
    tag_t  stored_tag;
    word_t stored_data;
    logic  stored_valid;

    // The fill strobe both writes and reads port 0, so the old line comes out
    dual_port_memory #(
        .entry_t ( tag_t )
    ) tag_memory (
        .clk_i         ( clk_i              ),
        .port0_index_i ( fill_i.addr.index  ),
        .port0_entry_i ( fill_i.addr.tag    ),
        .port0_write_i ( fill_i.write       ),
        .port0_read_i  ( fill_i.write       ),
        .port0_entry_o ( old_tag            ),
        .port1_index_i ( lookup_i.addr.index ),
        .port1_read_i  ( lookup_i.read      ),
        .port1_entry_o ( stored_tag         )
    );

    // Same wiring as the tags, only the payload differs
    dual_port_memory #(
        .entry_t ( word_t )
    ) data_memory (
        .clk_i         ( clk_i              ),
        .port0_index_i ( fill_i.addr.index  ),
        .port0_entry_i ( fill_i.data        ),
        .port0_write_i ( fill_i.write       ),
        .port0_read_i  ( fill_i.write       ),
        .port0_entry_o ( old_data           ),
        .port1_index_i ( lookup_i.addr.index ),
        .port1_read_i  ( lookup_i.read      ),
        .port1_entry_o ( stored_data        )
    );

    valid_memory valid_memory_i (
        .clk_i         ( clk_i               ),
        .reset_i       ( reset_i             ),
        .set_i         ( fill_i.write        ),
        .set_index_i   ( fill_i.addr.index   ),
        .clear_i       ( invalidate_i        ),
        .clear_index_i ( invalidate_index_i  ),
        .port0_read_i  ( fill_i.write        ),
        .port0_index_i ( fill_i.addr.index   ),
        .port0_valid_o ( old_valid           ),
        .port1_read_i  ( lookup_i.read       ),
        .port1_index_i ( lookup_i.addr.index ),
        .port1_valid_o ( stored_valid        )
    );

    // ------------------------------
    // Lookup and eviction paths
    // ------------------------------

    hit_detector hit_detector_i (
        .clk_i          ( clk_i        ),
        .reset_i        ( reset_i      ),
        .lookup_i       ( lookup_i     ),
        .stored_tag_i   ( stored_tag   ),
        .stored_data_i  ( stored_data  ),
        .stored_valid_i ( stored_valid ),
        .response_o     ( response_o   )
    );

    eviction_builder eviction_builder_i (
        .clk_i       ( clk_i     ),
        .reset_i     ( reset_i   ),
        .fill_i      ( fill_i    ),
        .old_tag_i   ( old_tag   ),
        .old_data_i  ( old_data  ),
        .old_valid_i ( old_valid ),
        .victim_o    ( victim_o  )
    );

endmodule : cache_lookup_top

// ==== dv/cache_lookup_properties.sv ====
module cache_lookup_properties import cache_pkg::*; (
    input logic         clk_i,
    input logic         reset_i,
    input lookup_req_t  lookup_i,
    input fill_req_t    fill_i,
    input lookup_resp_t response_i,
    input victim_t      victim_i
);

    // Number of assertion failures, read by the testbench at the end of the run
    int failure_count = 0;

    // ------------------------------
    // Output timing
    // ------------------------------

    // A lookup sampled at one edge shows its response at the second edge after it
    response_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        lookup_i.read |-> ##2 response_i.valid)
        else begin
            $error("response_o.valid did not follow a lookup two cycles later");
            failure_count++;
        end

    // No response without a lookup two cycles earlier
    response_source: assert property (@(posedge clk_i) disable iff (reset_i)
        response_i.valid |-> $past(lookup_i.read, 2))
        else begin
            $error("response_o.valid was raised without a lookup two cycles earlier");
            failure_count++;
        end

    // A victim only ever shows up one cycle after a fill
    victim_source: assert property (@(posedge clk_i) disable iff (reset_i)
        victim_i.valid |-> $past(fill_i.write))
        else begin
            $error("victim_o.valid was raised without a fill one cycle earlier");
            failure_count++;
        end

    response_hit_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        response_i.hit |-> response_i.valid)
        else begin
            $error("response_o.hit was raised without response_o.valid");
            failure_count++;
        end

    // Both pulses stay low in the first cycle out of reset
    outputs_after_reset: assert property (@(posedge clk_i)
        $fell(reset_i) |-> !response_i.valid && !victim_i.valid)
        else begin
            $error("A valid output was high in the first cycle after reset");
            failure_count++;
        end

endmodule : cache_lookup_properties

bind cache_lookup_top cache_lookup_properties cache_lookup_properties_i (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .lookup_i   ( lookup_i   ),
    .fill_i     ( fill_i     ),
    .response_i ( response_o ),
    .victim_i   ( victim_o   )
);

// ==== dv/cache_lookup_checker.sv ====
module cache_lookup_checker import cache_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,

    // DUT inputs and outputs as seen on the ports
    input  lookup_req_t  lookup_i,
    input  fill_req_t    fill_i,
    input  logic         invalidate_i,
    input  index_t       invalidate_index_i,
    input  lookup_resp_t response_i,
    input  victim_t      victim_i,

    // Row of the stimulus table that is applied in this cycle
    input  logic         row_active_i,
    input  logic [7:0]   test_id_i,
    input  logic         expect_hit_i,
    input  word_t        expect_data_i,
    input  victim_t      expect_victim_i,

    output int           check_count_o,
    output int           error_count_o,
    output int           done_count_o
);

    // One applied row on its way through the DUT
    typedef struct packed {
        logic         active;
        logic [7:0]   test_id;
        logic         lookup;
        logic         fill;
        lookup_resp_t model_resp;
        logic         table_hit;
        word_t        table_data;
        victim_t      model_victim;
        victim_t      table_victim;
        logic [7:0]   errors;
    } pending_t;

    // Slot 0 holds the row of the last edge, slot 1 the row of the edge before
    pending_t pending_q [2];

    // ------------------------------
    // Shadow copy of the cache lines
    // ------------------------------

    tag_t                     shadow_tag [CACHE_DEPTH];
    word_t                    shadow_data [CACHE_DEPTH];
    logic [CACHE_DEPTH - 1:0] shadow_valid;

    // Mismatches found for the row being checked right now
    int row_errors;

    initial begin
        check_count_o = 0;
        error_count_o = 0;
        done_count_o  = 0;
        row_errors    = 0;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count_o++;
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            error_count_o++;
            row_errors++;
        end
    endtask

    // A victim appears in the cycle after the fill edge
    task automatic check_victim();
        pending_t entry;
        entry = pending_q[0];
        row_errors = 0;
        compare("victim_o.valid", entry.model_victim.valid, victim_i.valid);
        if (entry.model_victim.valid) begin
            compare("victim_o.addr", entry.model_victim.addr, victim_i.addr);
            compare("victim_o.data", entry.model_victim.data, victim_i.data);
        end
        // The table is checked as well, so a wrong model cannot hide a wrong DUT
        if (entry.fill) begin
            compare("victim_o.valid (table)", entry.table_victim.valid, victim_i.valid);
            if (entry.table_victim.valid) begin
                compare("victim_o.addr (table)", entry.table_victim.addr, victim_i.addr);
                compare("victim_o.data (table)", entry.table_victim.data, victim_i.data);
            end
        end
        pending_q[0].errors = 8'(entry.errors + row_errors);
    endtask

    // A response appears two cycles after the lookup edge, which also ends the row
    task automatic check_response();
        pending_t entry;
        entry = pending_q[1];
        row_errors = 0;
        if (entry.lookup && !response_i.valid) begin
            $display("Lookup of test %0d got no response two cycles after the lookup",
                     entry.test_id);
        end
        compare("response_o.valid", entry.model_resp.valid, response_i.valid);
        if (entry.lookup) begin
            compare("response_o.hit", entry.model_resp.hit, response_i.hit);
            compare("response_o.data", entry.model_resp.data, response_i.data);
            compare("response_o.hit (table)", entry.table_hit, response_i.hit);
            compare("response_o.data (table)", entry.table_data, response_i.data);
        end
        if (entry.active) begin
            if (entry.errors + row_errors == 0) begin
                $display("Test %0d passed", entry.test_id);
            end else begin
                $display("Test %0d failed with %0d errors", entry.test_id,
                         entry.errors + row_errors);
            end
            done_count_o++;
        end
    endtask

    // Expected outputs come from the lines before the edge, then the edge is applied
    task automatic capture();
        pending_t entry;
        index_t   lookup_index;
        index_t   fill_index;
        lookup_index = lookup_i.addr.index;
        fill_index   = fill_i.addr.index;
        entry = '0;
        entry.active  = row_active_i;
        entry.test_id = test_id_i;
        entry.lookup  = lookup_i.read;
        entry.fill    = fill_i.write;
        entry.model_resp.valid = lookup_i.read;
        if (lookup_i.read && shadow_valid[lookup_index] &&
            shadow_tag[lookup_index] == lookup_i.addr.tag) begin
            entry.model_resp.hit  = 1'b1;
            entry.model_resp.data = shadow_data[lookup_index];
        end
        entry.table_hit    = expect_hit_i;
        entry.table_data   = expect_data_i;
        entry.table_victim = expect_victim_i;
        if (fill_i.write && shadow_valid[fill_index]) begin
            entry.model_victim.valid      = 1'b1;
            entry.model_victim.addr.tag   = shadow_tag[fill_index];
            entry.model_victim.addr.index = fill_index;
            entry.model_victim.data       = shadow_data[fill_index];
        end
        // Invalidate first, so a fill to the same index leaves the line valid
        if (invalidate_i) begin
            shadow_valid[invalidate_index_i] = 1'b0;
        end
        if (fill_i.write) begin
            shadow_valid[fill_index] = 1'b1;
            shadow_tag[fill_index]   = fill_i.addr.tag;
            shadow_data[fill_index]  = fill_i.data;
        end
        pending_q[0] = entry;
    endtask

    // ------------------------------
    // Sampling on the falling edge
    // ------------------------------

    // Inputs settle 1 unit after the rising edge and outputs right at it,
    // so the falling edge sees both stable
    always @(negedge clk_i) begin : watch
        if (reset_i) begin
            shadow_valid = '0;
            pending_q[0] = '0;
            pending_q[1] = '0;
        end else begin
            check_victim();
            check_response();
            pending_q[1] = pending_q[0];
            capture();
        end
    end : watch

endmodule : cache_lookup_checker

// ==== dv/cache_lookup_tb.sv ====
module cache_lookup_tb import cache_pkg::*; ();

    // One cycle of stimulus with the outputs it should produce
    typedef struct packed {
        lookup_req_t lookup;
        fill_req_t   fill;
        logic        invalidate;
        index_t      invalidate_index;
        logic        expect_hit;
        word_t       expect_data;
        victim_t     expect_victim;
    } stimulus_row_t;

    logic         clk_i;
    logic         reset_i;
    lookup_req_t  lookup_i;
    fill_req_t    fill_i;
    logic         invalidate_i;
    index_t       invalidate_index_i;
    lookup_resp_t response_o;
    victim_t      victim_o;

    // Expected values of the current row, handed to the checker
    logic         row_active;
    logic [7:0]   test_id;
    logic         expect_hit;
    word_t        expect_data;
    victim_t      expect_victim;

    int check_count;
    int error_count;
    int done_count;

    stimulus_row_t rows [$];

    cache_lookup_top cache_lookup_top_i (
        .clk_i              ( clk_i              ),
        .reset_i            ( reset_i            ),
        .lookup_i           ( lookup_i           ),
        .fill_i             ( fill_i             ),
        .invalidate_i       ( invalidate_i       ),
        .invalidate_index_i ( invalidate_index_i ),
        .response_o         ( response_o         ),
        .victim_o           ( victim_o           )
    );

    cache_lookup_checker cache_lookup_checker_i (
        .clk_i              ( clk_i              ),
        .reset_i            ( reset_i            ),
        .lookup_i           ( lookup_i           ),
        .fill_i             ( fill_i             ),
        .invalidate_i       ( invalidate_i       ),
        .invalidate_index_i ( invalidate_index_i ),
        .response_i         ( response_o         ),
        .victim_i           ( victim_o           ),
        .row_active_i       ( row_active         ),
        .test_id_i          ( test_id            ),
        .expect_hit_i       ( expect_hit         ),
        .expect_data_i      ( expect_data        ),
        .expect_victim_i    ( expect_victim      ),
        .check_count_o      ( check_count        ),
        .error_count_o      ( error_count        ),
        .done_count_o       ( done_count         )
    );

    always #2 clk_i = ~clk_i;

    // ------------------------------
    // Stimulus table
    // ------------------------------

    task automatic add_row(input logic lk, input cache_addr_t lk_addr, input logic fl,
                           input cache_addr_t fl_addr, input word_t fl_data,
                           input logic inv, input index_t inv_index, input logic hit,
                           input word_t data, input logic vv, input cache_addr_t v_addr,
                           input word_t v_data);
        stimulus_row_t row;
        row.lookup.read          = lk;
        row.lookup.addr          = lk_addr;
        row.fill.write           = fl;
        row.fill.addr            = fl_addr;
        row.fill.data            = fl_data;
        row.invalidate           = inv;
        row.invalidate_index     = inv_index;
        row.expect_hit           = hit;
        row.expect_data          = data;
        row.expect_victim.valid  = vv;
        row.expect_victim.addr   = v_addr;
        row.expect_victim.data   = v_data;
        rows.push_back(row);
    endtask

    // Addresses are {tag, index}, so 12'h123 is tag 8'h12 at line 3
    task automatic build_table();
        // Columns: lookup, lookup addr, fill, fill addr, fill data, invalidate,
        // invalidate index, hit, data, victim valid, victim addr, victim data
        for (int i = 0; i < CACHE_DEPTH; i++) begin
            add_row(1, {8'h00, index_t'(i)}, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        end
        add_row(0, 0, 1, 12'h123, 32'hA5A5_0003, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, 12'h123, 0, 0, 0, 0, 0, 1, 32'hA5A5_0003, 0, 0, 0);
        add_row(1, 12'h343, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // Replacing a valid line reports the old tag, index and data
        add_row(0, 0, 1, 12'h563, 32'hBEEF_0003, 0, 0, 0, 0, 1, 12'h123, 32'hA5A5_0003);
        add_row(0, 0, 1, 12'h215, 32'h1111_0005, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, 12'h215, 0, 0, 0, 0, 0, 1, 32'h1111_0005, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, 1, 4'h5, 0, 0, 0, 0, 0);
        add_row(1, 12'h215, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // Fill and invalidate on one edge, the fill wins
        add_row(0, 0, 1, 12'h777, 32'h7777_0007, 1, 4'h7, 0, 0, 0, 0, 0);
        add_row(1, 12'h777, 0, 0, 0, 0, 0, 1, 32'h7777_0007, 0, 0, 0);
        // Lookup and fill to line 3 on one edge see the old line
        add_row(1, 12'h563, 1, 12'h993, 32'h9999_0003, 0, 0, 1, 32'hBEEF_0003,
                1, 12'h563, 32'hBEEF_0003);
        add_row(1, 12'h993, 0, 0, 0, 0, 0, 1, 32'h9999_0003, 0, 0, 0);
        // Back-to-back lookups to different lines
        add_row(1, 12'h993, 0, 0, 0, 0, 0, 1, 32'h9999_0003, 0, 0, 0);
        add_row(1, 12'h777, 0, 0, 0, 0, 0, 1, 32'h7777_0007, 0, 0, 0);
        add_row(1, 12'h215, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, 12'h129, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic drive_idle();
        lookup_i           = '0;
        fill_i             = '0;
        invalidate_i       = 1'b0;
        invalidate_index_i = '0;
        row_active         = 1'b0;
        test_id            = '0;
        expect_hit         = 1'b0;
        expect_data        = '0;
        expect_victim      = '0;
    endtask

    task automatic apply_row(input int n);
        lookup_i           = rows[n].lookup;
        fill_i             = rows[n].fill;
        invalidate_i       = rows[n].invalidate;
        invalidate_index_i = rows[n].invalidate_index;
        row_active         = 1'b1;
        test_id            = 8'(n + 1);
        expect_hit         = rows[n].expect_hit;
        expect_data        = rows[n].expect_data;
        expect_victim      = rows[n].expect_victim;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin : main
        int  cycles;
        int  assertion_failures;
        logic timed_out;
        clk_i   = 1'b0;
        reset_i = 1'b1;
        drive_idle();
        build_table();
        repeat (5) @(posedge clk_i);
        #1 reset_i = 1'b0;
        for (int n = 0; n < rows.size(); n++) begin
            @(posedge clk_i);
            #1 apply_row(n);
        end
        @(posedge clk_i);
        #1 drive_idle();
        // The last rows still have responses in flight
        cycles = 0;
        while (done_count < rows.size() && cycles < 50) begin
            @(posedge clk_i);
            cycles++;
        end
        timed_out = (done_count < rows.size());
        assertion_failures = cache_lookup_top_i.cache_lookup_properties_i.failure_count;
        $display("%0d of %0d tests finished, %0d checks, %0d errors, %0d assertion failures",
                 done_count, rows.size(), check_count, error_count, assertion_failures);
        if (timed_out || error_count != 0 || assertion_failures != 0) begin
            if (timed_out) begin
                $display("Timed out waiting for the responses of the last tests");
            end
            $display("Simulation failed");
        end else begin
            $display("Simulation completed successfully");
        end
        $finish;
    end : main

endmodule : cache_lookup_tb

// ==== all.f ====
source/cache_pkg.sv
source/dual_port_memory.sv
source/valid_memory.sv
source/hit_detector.sv
source/eviction_builder.sv
source/cache_lookup_top.sv
dv/cache_lookup_properties.sv
dv/cache_lookup_checker.sv
dv/cache_lookup_tb.sv
